/* vec_issue.f */
+incdir+.
vec_issue_pkg.sv
vec_decoder.sv
inst_buffer.sv
convoy_ctrl.sv
dispatch_unit.sv
vec_issue_top.sv
tb_vec_issue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vec_issue
FLIST     ?= vec_issue.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tb_vec_issue.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vec_issue_params.svh"

module tb_vec_issue;

	localparam logic [31:0] NOP = 32'h0000_0013; // Canonical addi no-op
	localparam int N_TESTS  = 10;
	localparam int CYC_MAX  = 80;                // Worst case cycles of one convoy test
	localparam int TIMEOUT  = (N_TESTS * CYC_MAX + 20) * 20;

	// DUT inputs
	logic                reset;       // Clock
	logic                clk;         // Async active high reset
	logic [`VI_XLEN-1:0] instr;
	logic [`VI_XLEN-1:0] rs1_data;
	logic [`VI_XLEN-1:0] rs2_data;
	logic                branch_taken;
	logic                hold;
	logic                exe_stall;
	logic                exe_done;

	// DUT outputs
	wire                    v_stall, freeze, issue_start, issue_clear;
	wire [`VI_REG_W-1:0]    rs1_sel, rs2_sel, issue_vs1, issue_vs2, issue_vd;
	wire [`VI_SLOT_W-1:0]   issue_id;
	wire [`VI_FUNCT_W-1:0]  issue_funct;
	wire vec_issue_pkg::alu_src_e issue_alu_src;
	wire                    issue_mask_en, issue_mem_rd, issue_mem_wr, issue_reg_we, issue_mem_reg;
	wire [1:0]              issue_mode_lsu;
	wire [`VI_XLEN-1:0]     issue_rs1, issue_rs2;
	wire [29:0]             issue_bundle;

	// Reference model state
	integer      seed = 32'h2c;
	logic [31:0] exp_instr [`VI_NLANES]; // Vector instructions recorded in this window
	int          exp_n;
	int          issue_cnt;  // Issues seen in the current convoy
	logic        aborted;    // Branch killed the current convoy
	logic        start_conv; // First vector of a convoy on instr
	logic        sc_intr;    // Unheld scalar inside the window

	assign issue_bundle = {issue_vs1, issue_vs2, issue_vd, issue_funct, issue_alu_src,
		issue_mask_en, issue_mem_rd, issue_mem_wr, issue_reg_we, issue_mem_reg, issue_mode_lsu};

	vec_issue_top i_vec_issue_top (
		.reset (reset), .clk (clk), .instr (instr),
		.rs1_data (rs1_data), .rs2_data (rs2_data),
		.branch_taken (branch_taken), .hold (hold),
		.exe_stall (exe_stall), .exe_done (exe_done),
		.v_stall (v_stall), .freeze (freeze),
		.rs1_sel (rs1_sel), .rs2_sel (rs2_sel),
		.issue_start (issue_start), .issue_clear (issue_clear), .issue_id (issue_id),
		.issue_vs1 (issue_vs1), .issue_vs2 (issue_vs2), .issue_vd (issue_vd),
		.issue_funct (issue_funct), .issue_alu_src (issue_alu_src),
		.issue_mask_en (issue_mask_en), .issue_mem_rd (issue_mem_rd),
		.issue_mem_wr (issue_mem_wr), .issue_reg_we (issue_reg_we),
		.issue_mem_reg (issue_mem_reg), .issue_mode_lsu (issue_mode_lsu),
		.issue_rs1 (issue_rs1), .issue_rs2 (issue_rs2)
	);

	////////////////////////////////////////
	// Reference decode and helpers
	////////////////////////////////////////
	function automatic logic [29:0] decode_fields(input logic [31:0] i);
		logic       ld;
		logic       st;
		logic       ar;
		logic [1:0] src;
		ld = (i[6:0] == 7'b0000111);
		st = (i[6:0] == 7'b0100111);
		ar = (i[6:0] == 7'b1010111);
		case (i[14:12])
			3'b100:  src = 2'b01; // Scalar operand
			3'b011:  src = 2'b11; // Immediate
			default: src = 2'b00;
		endcase
		return {i[19:15], i[24:20], i[11:7], i[31:26], src,
			~i[25], ld, st, ld | ar, ld, i[27:26]};
	endfunction

	function automatic logic [31:0] rand_vec();
		logic [31:0] r;
		int          k;
		r = $random(seed);
		k = {$random(seed)} % 3;
		case (k)
			0:       r[6:0] = 7'b0000111; // Load
			1:       r[6:0] = 7'b0100111; // Store
			default: r[6:0] = 7'b1010111; // Arithmetic
		endcase
		return r;
	endfunction

	function automatic logic [31:0] rand_scalar();
		logic [31:0] r;
		r = $random(seed);
		r[6:0] = 7'b0110011; // R-type integer op
		return r;
	endfunction

	task automatic fail_with(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1, "Run stopped on a failed check");
	endtask

	// Falling edge drive point with fresh scalar operands
	task automatic tick();
		@(negedge reset);
		rs1_data = $random(seed);
		rs2_data = $random(seed);
	endtask

	// Issue counter and abort flag
	always @(posedge reset or posedge clk) begin
		if (clk) begin
			issue_cnt <= 0;
			aborted   <= 1'b0;
		end else begin
			if (!v_stall)
				issue_cnt <= 0;
			else if (issue_start)
				issue_cnt <= issue_cnt + 1;
			if (branch_taken)
				aborted <= 1'b1;
			else if (start_conv)
				aborted <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	a_reset: assert property (@(posedge reset) ((clk && $past(clk)) || $fell(clk)) |->
		(!v_stall && !freeze && !issue_start && issue_clear))
		else fail_with($sformatf(
			"MISMATCH reset v_stall=%h freeze=%h issue_start=%h issue_clear=%h",
			$sampled(v_stall), $sampled(freeze), $sampled(issue_start), $sampled(issue_clear)));

	a_stall_on: assert property (@(posedge reset) disable iff (clk)
		start_conv && !hold |=> v_stall)
		else fail_with("v_stall did not rise when the first vector instruction was recorded");

	a_id: assert property (@(posedge reset) disable iff (clk)
		issue_start |-> issue_id == issue_cnt[`VI_SLOT_W-1:0])
		else fail_with($sformatf("MISMATCH issue_id got %h exp %h",
			$sampled(issue_id), $sampled(issue_cnt)));

	a_fields: assert property (@(posedge reset) disable iff (clk)
		issue_start |-> issue_bundle == decode_fields(exp_instr[issue_cnt[2:0]]))
		else fail_with($sformatf("MISMATCH issue_bundle got %h exp %h", $sampled(issue_bundle),
			decode_fields(exp_instr[$sampled(issue_cnt[2:0])])));

	a_rs1: assert property (@(posedge reset) disable iff (clk)
		issue_start |-> issue_rs1 == $past(rs1_data) && issue_rs2 == $past(rs2_data))
		else fail_with($sformatf("MISMATCH issue_rs1/issue_rs2 got %h/%h exp %h/%h",
			$sampled(issue_rs1), $sampled(issue_rs2), $past(rs1_data), $past(rs2_data)));

	a_sel: assert property (@(posedge reset) disable iff (clk)
		issue_start |-> $past(rs1_sel) == exp_instr[issue_cnt[2:0]][19:15] &&
			$past(rs2_sel) == exp_instr[issue_cnt[2:0]][24:20])
		else fail_with($sformatf("MISMATCH rs1_sel/rs2_sel got %h/%h exp %h/%h",
			$past(rs1_sel), $past(rs2_sel), exp_instr[$sampled(issue_cnt[2:0])][19:15],
			exp_instr[$sampled(issue_cnt[2:0])][24:20]));

	a_no_stall_issue: assert property (@(posedge reset) disable iff (clk)
		issue_start |-> !$past(exe_stall) && v_stall && freeze)
		else fail_with("issue_start came after a stalled cycle or outside a frozen convoy");

	a_intr: assert property (@(posedge reset) disable iff (clk) sc_intr |=> freeze)
		else fail_with("Scalar instruction in the window did not raise freeze");

	a_release: assert property (@(posedge reset) disable iff (clk)
		$fell(v_stall) |-> !freeze && issue_clear && (aborted || issue_cnt == exp_n))
		else fail_with($sformatf("MISMATCH release freeze=%h issue_clear=%h issues %h exp %h",
			$sampled(freeze), $sampled(issue_clear), $sampled(issue_cnt), $sampled(exp_n)));

	a_abort: assert property (@(posedge reset) disable iff (clk)
		branch_taken |=> !v_stall && !freeze && issue_clear)
		else fail_with("Taken branch did not return control to the scalar pipeline");

	a_no_issue_after_abort: assert property (@(posedge reset) disable iff (clk)
		aborted |-> !issue_start)
		else fail_with("issue_start pulsed after the convoy was aborted");

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	task automatic collect(input int n, input bit use_hold, input int abort_u);
		int          u;
		bit          intr;
		logic [31:0] v;
		u    = 0;
		intr = 0;
		exp_n = 0;
		while (u < `VI_NLANES) begin
			tick();
			start_conv   = (u == 0);
			sc_intr      = 1'b0;
			branch_taken = 1'b0;
			hold         = 1'b0;
			if (u > 0 && use_hold && ({$random(seed)} % 4 == 0)) begin
				hold  = 1'b1;
				instr = rand_vec(); // Held vector is not recorded
			end else if (u == abort_u) begin
				branch_taken = 1'b1;
				instr        = NOP;
				u            = `VI_NLANES;
			end else begin
				if (u < n || u == n + 1) begin // Late vector after the interruption
					v     = rand_vec();
					instr = v;
					if (!intr) begin
						exp_instr[exp_n] = v;
						exp_n++;
					end
				end else begin
					instr   = rand_scalar();
					intr    = 1;
					sc_intr = 1'b1;
				end
				u++;
			end
		end
		tick();
		start_conv   = 1'b0;
		sc_intr      = 1'b0;
		branch_taken = 1'b0;
		hold         = 1'b0;
		instr        = NOP;
	endtask

	task automatic drain(input bit use_stall, input bit use_hold, input int abort_t);
		int k;
		k = 0;
		while (v_stall) begin // Runs until release or abort
			tick();
			exe_stall    = use_stall && ({$random(seed)} % 3 == 0);
			hold         = use_hold && ({$random(seed)} % 4 == 0);
			branch_taken = (k == abort_t);
			exe_done     = (issue_cnt == exp_n);
			k++;
		end
		tick();
		exe_stall    = 1'b0;
		hold         = 1'b0;
		branch_taken = 1'b0;
		exe_done     = 1'b0;
	endtask

	task automatic run_test(input int n, input bit use_hold, input bit use_stall,
		input int abort_u, input int abort_t);
		collect(n, use_hold, abort_u);
		if (v_stall)
			drain(use_stall, use_hold, abort_t);
		repeat (3) tick(); // Let the delayed branch copy clear
	endtask

	initial begin
		reset = 1'b0;
		forever #10 reset = ~reset;
	end

	initial begin
		#(TIMEOUT);
		$display("Watchdog expired before the tests finished");
		$display("Some tests failed");
		$fatal(1, "Timeout");
	end

	initial begin
		clk          = 1'b1;
		instr        = NOP;
		rs1_data     = '0;
		rs2_data     = '0;
		branch_taken = 1'b0;
		hold         = 1'b0;
		exe_stall    = 1'b0;
		exe_done     = 1'b0;
		start_conv   = 1'b0;
		sc_intr      = 1'b0;
		exp_n        = 0;
		repeat (2) @(negedge reset);
		clk = 1'b0;
		repeat (2) tick();
		run_test(8, 0, 0, -1, -1); // Full window
		run_test(1, 0, 0, -1, -1); // Single entry
		run_test(3, 1, 0, -1, -1); // Held cycles stretch the window
		run_test(5, 0, 1, -1, -1); // Back-pressure
		run_test(8, 1, 1, -1, -1);
		run_test(6, 1, 1, -1, -1);
		run_test(8, 0, 0, 4, -1);  // Branch during collection
		run_test(7, 0, 1, -1, 2);  // Branch during dispatch
		run_test(2, 0, 1, -1, -1);
		run_test(4, 1, 0, -1, -1);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* vec_issue_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vec_issue_params.svh"

module vec_issue_top (
	input  wire                     reset,        // Clock
	input  wire                     clk,          // Async reset, active high
	input  wire [`VI_XLEN-1:0]      instr,        // ID/EX instruction
	input  wire [`VI_XLEN-1:0]      rs1_data,
	input  wire [`VI_XLEN-1:0]      rs2_data,
	input  wire                     branch_taken,
	input  wire                     hold,
	input  wire                     exe_stall,
	input  wire                     exe_done,
	output logic                    v_stall,
	output logic                    freeze,
	output logic [`VI_REG_W-1:0]    rs1_sel,
	output logic [`VI_REG_W-1:0]    rs2_sel,
	output logic                    issue_start,
	output logic                    issue_clear,
	output logic [`VI_SLOT_W-1:0]   issue_id,
	output logic [`VI_REG_W-1:0]    issue_vs1,
	output logic [`VI_REG_W-1:0]    issue_vs2,
	output logic [`VI_REG_W-1:0]    issue_vd,
	output logic [`VI_FUNCT_W-1:0]  issue_funct,
	output vec_issue_pkg::alu_src_e issue_alu_src,
	output logic                    issue_mask_en,
	output logic                    issue_mem_rd,
	output logic                    issue_mem_wr,
	output logic                    issue_reg_we,
	output logic                    issue_mem_reg,
	output logic [1:0]              issue_mode_lsu,
	output logic [`VI_XLEN-1:0]     issue_rs1,
	output logic [`VI_XLEN-1:0]     issue_rs2
);

	// Decoder to buffer
	wire                          is_vec;
	wire [`VI_REG_W-1:0]          dec_vs1, dec_vs2, dec_vd, dec_rs1_idx, dec_rs2_idx;
	wire [`VI_FUNCT_W-1:0]        dec_funct;
	wire vec_issue_pkg::alu_src_e dec_alu_src;
	wire                          dec_mask_en, dec_mem_rd, dec_mem_wr, dec_reg_we, dec_mem_reg;
	wire [1:0]                    dec_mode_lsu;

	// Buffer read port to dispatcher
	wire [`VI_SLOT_W-1:0]         rd_slot;
	wire [`VI_CNT_W-1:0]          count;
	wire [`VI_REG_W-1:0]          rd_vs1, rd_vs2, rd_vd, rd_rs1_idx, rd_rs2_idx;
	wire [`VI_FUNCT_W-1:0]        rd_funct;
	wire vec_issue_pkg::alu_src_e rd_alu_src;
	wire                          rd_mask_en, rd_mem_rd, rd_mem_wr, rd_reg_we, rd_mem_reg;
	wire [1:0]                    rd_mode_lsu;

	// Controller strobes
	wire rec_we, abort, dispatch_en, release_done, dispatch_last;

	vec_decoder i_vec_decoder (
		.instr   (instr),
		.is_vec  (is_vec),
		.vs1     (dec_vs1),     .vs2     (dec_vs2),     .vd      (dec_vd),
		.rs1_idx (dec_rs1_idx), .rs2_idx (dec_rs2_idx), .funct   (dec_funct),
		.alu_src (dec_alu_src), .mask_en (dec_mask_en), .mem_rd  (dec_mem_rd),
		.mem_wr  (dec_mem_wr),  .reg_we  (dec_reg_we),  .mem_reg (dec_mem_reg),
		.mode_lsu(dec_mode_lsu)
	);

	inst_buffer i_inst_buffer (
		.reset       (reset),       .clk        (clk),
		.rec_we      (rec_we),      .abort      (abort), .release_done (release_done),
		.vs1         (dec_vs1),     .vs2        (dec_vs2),     .vd      (dec_vd),
		.rs1_idx     (dec_rs1_idx), .rs2_idx    (dec_rs2_idx), .funct   (dec_funct),
		.alu_src     (dec_alu_src), .mask_en    (dec_mask_en), .mem_rd  (dec_mem_rd),
		.mem_wr      (dec_mem_wr),  .reg_we     (dec_reg_we),  .mem_reg (dec_mem_reg),
		.mode_lsu    (dec_mode_lsu),
		.rd_slot     (rd_slot),
		.rd_vs1      (rd_vs1),      .rd_vs2     (rd_vs2),      .rd_vd   (rd_vd),
		.rd_rs1_idx  (rd_rs1_idx),  .rd_rs2_idx (rd_rs2_idx),  .rd_funct(rd_funct),
		.rd_alu_src  (rd_alu_src),  .rd_mask_en (rd_mask_en),  .rd_mem_rd (rd_mem_rd),
		.rd_mem_wr   (rd_mem_wr),   .rd_reg_we  (rd_reg_we),   .rd_mem_reg(rd_mem_reg),
		.rd_mode_lsu (rd_mode_lsu),
		.count       (count)
	);

	convoy_ctrl i_convoy_ctrl (
		.reset        (reset),        .clk          (clk),
		.is_vec       (is_vec),       .hold         (hold),
		.branch_taken (branch_taken), .exe_done     (exe_done),
		.dispatch_last(dispatch_last),
		.rec_we       (rec_we),       .abort        (abort),
		.dispatch_en  (dispatch_en),  .release_done (release_done),
		.v_stall      (v_stall),      .freeze       (freeze)
	);

	dispatch_unit i_dispatch_unit (
		.reset         (reset),         .clk          (clk),
		.dispatch_en   (dispatch_en),   .abort        (abort),
		.release_done  (release_done),  .exe_stall    (exe_stall),
		.count         (count),
		.rd_vs1        (rd_vs1),        .rd_vs2       (rd_vs2),     .rd_vd     (rd_vd),
		.rd_rs1_idx    (rd_rs1_idx),    .rd_rs2_idx   (rd_rs2_idx), .rd_funct  (rd_funct),
		.rd_alu_src    (rd_alu_src),    .rd_mask_en   (rd_mask_en), .rd_mem_rd (rd_mem_rd),
		.rd_mem_wr     (rd_mem_wr),     .rd_reg_we    (rd_reg_we),  .rd_mem_reg(rd_mem_reg),
		.rd_mode_lsu   (rd_mode_lsu),
		.rs1_data      (rs1_data),      .rs2_data     (rs2_data),
		.rd_slot       (rd_slot),       .dispatch_last(dispatch_last),
		.rs1_sel       (rs1_sel),       .rs2_sel      (rs2_sel),
		.issue_start   (issue_start),   .issue_clear  (issue_clear),
		.issue_id      (issue_id),
		.issue_vs1     (issue_vs1),     .issue_vs2    (issue_vs2),  .issue_vd  (issue_vd),
		.issue_funct   (issue_funct),   .issue_alu_src(issue_alu_src),
		.issue_mask_en (issue_mask_en), .issue_mem_rd (issue_mem_rd),
		.issue_mem_wr  (issue_mem_wr),  .issue_reg_we (issue_reg_we),
		.issue_mem_reg (issue_mem_reg), .issue_mode_lsu(issue_mode_lsu),
		.issue_rs1     (issue_rs1),     .issue_rs2    (issue_rs2)
	);

endmodule

`default_nettype wire

/* dispatch_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vec_issue_params.svh"

module dispatch_unit (
	input  wire                     reset,        // Clock
	input  wire                     clk,          // Async reset, active high
	input  wire                     dispatch_en,
	input  wire                     abort,
	input  wire                     release_done,
	input  wire                     exe_stall,    // Back-pressure from the execution unit
	input  wire [`VI_CNT_W-1:0]     count,
	input  wire [`VI_REG_W-1:0]     rd_vs1,
	input  wire [`VI_REG_W-1:0]     rd_vs2,
	input  wire [`VI_REG_W-1:0]     rd_vd,
	input  wire [`VI_REG_W-1:0]     rd_rs1_idx,
	input  wire [`VI_REG_W-1:0]     rd_rs2_idx,
	input  wire [`VI_FUNCT_W-1:0]   rd_funct,
	input  wire vec_issue_pkg::alu_src_e rd_alu_src,
	input  wire                     rd_mask_en,
	input  wire                     rd_mem_rd,
	input  wire                     rd_mem_wr,
	input  wire                     rd_reg_we,
	input  wire                     rd_mem_reg,
	input  wire [1:0]               rd_mode_lsu,
	input  wire [`VI_XLEN-1:0]      rs1_data,     // Scalar register file read data
	input  wire [`VI_XLEN-1:0]      rs2_data,
	output logic [`VI_SLOT_W-1:0]   rd_slot,
	output logic                    dispatch_last,
	output logic [`VI_REG_W-1:0]    rs1_sel,
	output logic [`VI_REG_W-1:0]    rs2_sel,
	output logic                    issue_start,
	output logic                    issue_clear,
	output logic [`VI_SLOT_W-1:0]   issue_id,
	output logic [`VI_REG_W-1:0]    issue_vs1,
	output logic [`VI_REG_W-1:0]    issue_vs2,
	output logic [`VI_REG_W-1:0]    issue_vd,
	output logic [`VI_FUNCT_W-1:0]  issue_funct,
	output vec_issue_pkg::alu_src_e issue_alu_src,
	output logic                    issue_mask_en,
	output logic                    issue_mem_rd,
	output logic                    issue_mem_wr,
	output logic                    issue_reg_we,
	output logic                    issue_mem_reg,
	output logic [1:0]              issue_mode_lsu,
	output logic [`VI_XLEN-1:0]     issue_rs1,
	output logic [`VI_XLEN-1:0]     issue_rs2
);

	logic [`VI_CNT_W-1:0] ptr; // Next entry, wide enough to reach count
	wire                  do_issue;
	wire                  is_last;

	assign rd_slot  = ptr[`VI_SLOT_W-1:0];
	assign do_issue = dispatch_en && !exe_stall && !abort && (ptr < count);
	assign is_last  = (ptr == count - 1'b1);

	// Scalar register file addresses for the entry about to go out
	assign rs1_sel = rd_rs1_idx;
	assign rs2_sel = rd_rs2_idx;

	////////////////////////////////////////
	// Issue control
	////////////////////////////////////////
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			ptr           <= '0;
			issue_start   <= 1'b0;
			issue_clear   <= 1'b1; // Execution unit starts cleared
			dispatch_last <= 1'b0;
		end else begin
			issue_start   <= do_issue;
			dispatch_last <= do_issue && is_last;
			if (abort || release_done) begin
				ptr         <= '0;
				issue_clear <= 1'b1;
			end else if (do_issue) begin
				ptr         <= ptr + 1'b1;
				issue_clear <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Issue payload
	////////////////////////////////////////
	always_ff @(posedge reset) begin
		if (do_issue) begin
			issue_id       <= rd_slot;
			issue_vs1      <= rd_vs1;
			issue_vs2      <= rd_vs2;
			issue_vd       <= rd_vd;
			issue_funct    <= rd_funct;
			issue_alu_src  <= rd_alu_src;
			issue_mask_en  <= rd_mask_en;
			issue_mem_rd   <= rd_mem_rd;
			issue_mem_wr   <= rd_mem_wr;
			issue_reg_we   <= rd_reg_we;
			issue_mem_reg  <= rd_mem_reg;
			issue_mode_lsu <= rd_mode_lsu;
			issue_rs1      <= rs1_data; // Read with rs1_sel this cycle
			issue_rs2      <= rs2_data;
		end
	end

endmodule

`default_nettype wire

/* convoy_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vec_issue_params.svh"

module convoy_ctrl (
	input  wire  reset,         // Clock
	input  wire  clk,           // Async reset, active high
	input  wire  is_vec,        // Decoded ID/EX instruction is vector
	input  wire  hold,          // Data cache freeze
	input  wire  branch_taken,  // EX/MEM taken branch
	input  wire  exe_done,      // Execution unit finished the convoy
	input  wire  dispatch_last, // Final issue went out
	output logic rec_we,
	output logic abort,
	output logic dispatch_en,
	output logic release_done,
	output logic v_stall,       // Stall fetch
	output logic freeze         // Stall the whole scalar pipeline
);

	localparam int REL_W = $clog2(`VI_RELEASE_THD + 1);

	vec_issue_pkg::conv_state_e state;
	logic [`VI_SLOT_W-1:0] cyc_cnt; // Unheld cycles of the window
	logic [REL_W-1:0]      rel_cnt; // Unheld cycles since exe_done
	logic                  br_dly;  // Branch pulse one stage later
	logic                  x_int;   // Scalar instruction broke the window
	wire                   kill;
	wire                   win_end;
	wire                   rel_run;

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////
	assign kill    = branch_taken | br_dly;
	assign abort   = kill && (state != vec_issue_pkg::CS_IDLE);
	assign win_end = (state == vec_issue_pkg::CS_COLLECT) && !hold &&
		(cyc_cnt == `VI_SLOT_W'(`VI_NLANES - 1));

	// Record an unheld vector instruction at convoy start or inside the window
	assign rec_we = is_vec && !hold && !kill &&
		((state == vec_issue_pkg::CS_IDLE) ||
		 (state == vec_issue_pkg::CS_COLLECT && !x_int));

	assign dispatch_en  = (state == vec_issue_pkg::CS_DISPATCH);
	assign rel_run      = (state == vec_issue_pkg::CS_DRAIN) && !hold &&
		(exe_done || rel_cnt != '0);                         // Keeps going once started
	assign release_done = rel_run && (rel_cnt == REL_W'(`VI_RELEASE_THD - 1));

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			br_dly <= 1'b0;
		end else begin
			br_dly <= branch_taken;
		end
	end

	////////////////////////////////////////
	// Convoy FSM
	////////////////////////////////////////
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state   <= vec_issue_pkg::CS_IDLE;
			cyc_cnt <= '0;
			rel_cnt <= '0;
			x_int   <= 1'b0;
			v_stall <= 1'b0;
			freeze  <= 1'b0;
		end else if (abort || release_done) begin // Hand control back to the scalar core
			state   <= vec_issue_pkg::CS_IDLE;
			cyc_cnt <= '0;
			rel_cnt <= '0;
			x_int   <= 1'b0;
			v_stall <= 1'b0;
			freeze  <= 1'b0;
		end else begin
			case (state)
				vec_issue_pkg::CS_IDLE: begin
					if (rec_we) begin
						state   <= vec_issue_pkg::CS_COLLECT;
						cyc_cnt <= `VI_SLOT_W'(1); // First window cycle used here
						v_stall <= 1'b1;
					end
				end
				vec_issue_pkg::CS_COLLECT: begin
					if (!hold) begin
						cyc_cnt <= cyc_cnt + 1'b1; // Window stretches over held cycles
					end
					if (!hold && !is_vec) begin
						x_int  <= 1'b1;
						freeze <= 1'b1; // Scalar interruption
					end
					if (win_end) begin
						state  <= vec_issue_pkg::CS_DISPATCH;
						freeze <= 1'b1; // Window full
					end
				end
				vec_issue_pkg::CS_DISPATCH: begin
					if (dispatch_last) begin
						state <= vec_issue_pkg::CS_DRAIN;
					end
				end
				vec_issue_pkg::CS_DRAIN: begin
					if (rel_run) begin
						rel_cnt <= rel_cnt + 1'b1;
					end
				end
				default: state <= vec_issue_pkg::CS_IDLE;
			endcase
		end
	end

	// Fetch stall belongs to an active convoy only
	a_idle_no_stall: assert property (@(posedge reset) disable iff (clk)
		state == vec_issue_pkg::CS_IDLE |-> !v_stall)
		else $error("v_stall is high while the controller is idle");

	a_rec_phase: assert property (@(posedge reset) disable iff (clk)
		rec_we |-> (state inside {vec_issue_pkg::CS_IDLE, vec_issue_pkg::CS_COLLECT}))
		else $error("Instruction recorded outside the collection phase");

endmodule

`default_nettype wire

/* inst_buffer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vec_issue_params.svh"

module inst_buffer (
	input  wire                     reset,        // Clock
	input  wire                     clk,          // Async reset, active high
	input  wire                     rec_we,       // Record strobe from the controller
	input  wire                     abort,
	input  wire                     release_done,
	input  wire [`VI_REG_W-1:0]     vs1,
	input  wire [`VI_REG_W-1:0]     vs2,
	input  wire [`VI_REG_W-1:0]     vd,
	input  wire [`VI_REG_W-1:0]     rs1_idx,
	input  wire [`VI_REG_W-1:0]     rs2_idx,
	input  wire [`VI_FUNCT_W-1:0]   funct,
	input  wire vec_issue_pkg::alu_src_e alu_src,
	input  wire                     mask_en,
	input  wire                     mem_rd,
	input  wire                     mem_wr,
	input  wire                     reg_we,
	input  wire                     mem_reg,
	input  wire [1:0]               mode_lsu,
	input  wire [`VI_SLOT_W-1:0]    rd_slot,      // Read index from the dispatcher
	output logic [`VI_REG_W-1:0]    rd_vs1,
	output logic [`VI_REG_W-1:0]    rd_vs2,
	output logic [`VI_REG_W-1:0]    rd_vd,
	output logic [`VI_REG_W-1:0]    rd_rs1_idx,
	output logic [`VI_REG_W-1:0]    rd_rs2_idx,
	output logic [`VI_FUNCT_W-1:0]  rd_funct,
	output vec_issue_pkg::alu_src_e rd_alu_src,
	output logic                    rd_mask_en,
	output logic                    rd_mem_rd,
	output logic                    rd_mem_wr,
	output logic                    rd_reg_we,
	output logic                    rd_mem_reg,
	output logic [1:0]              rd_mode_lsu,
	output logic [`VI_CNT_W-1:0]    count         // Recorded entries
);

	// Five register indices, funct6, alu_src, five flags and mode_lsu
	localparam int ENT_W = 5 * `VI_REG_W + `VI_FUNCT_W + 9;

	logic [ENT_W-1:0]      mem [`VI_NLANES];
	logic [`VI_SLOT_W-1:0] wr_ptr;
	wire  [ENT_W-1:0]      wr_entry;
	wire  [ENT_W-1:0]      rd_entry;

	assign wr_entry = {vs1, vs2, vd, rs1_idx, rs2_idx, funct, alu_src,
		mask_en, mem_rd, mem_wr, reg_we, mem_reg, mode_lsu};

	////////////////////////////////////////
	// Entry storage
	////////////////////////////////////////
	always_ff @(posedge reset) begin
		if (rec_we) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	// Write pointer and occupancy
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			wr_ptr <= '0;
			count  <= '0;
		end else if (abort || release_done) begin // Convoy dropped or retired
			wr_ptr <= '0;
			count  <= '0;
		end else if (rec_we) begin
			wr_ptr <= wr_ptr + 1'b1;
			count  <= count + 1'b1;
		end
	end

	////////////////////////////////////////
	// Read port
	////////////////////////////////////////
	assign rd_entry = mem[rd_slot];

	assign {rd_vs1, rd_vs2, rd_vd, rd_rs1_idx, rd_rs2_idx, rd_funct} = rd_entry[ENT_W-1:9];
	assign rd_alu_src = vec_issue_pkg::alu_src_e'(rd_entry[8:7]);
	assign {rd_mask_en, rd_mem_rd, rd_mem_wr, rd_reg_we, rd_mem_reg, rd_mode_lsu} = rd_entry[6:0];

	// The controller window must never outrun the buffer
	a_no_overflow: assert property (@(posedge reset) disable iff (clk)
		rec_we |-> count != `VI_CNT_W'(`VI_NLANES))
		else $error("Record strobe arrived with the instruction buffer full");

endmodule

`default_nettype wire

/* vec_decoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vec_issue_params.svh"

module vec_decoder (
	input  wire [`VI_XLEN-1:0]     instr,    // ID/EX instruction
	output logic                   is_vec,
	output logic [`VI_REG_W-1:0]   vs1,
	output logic [`VI_REG_W-1:0]   vs2,
	output logic [`VI_REG_W-1:0]   vd,
	output logic [`VI_REG_W-1:0]   rs1_idx,
	output logic [`VI_REG_W-1:0]   rs2_idx,
	output logic [`VI_FUNCT_W-1:0] funct,
	output vec_issue_pkg::alu_src_e alu_src,
	output logic                   mask_en,
	output logic                   mem_rd,
	output logic                   mem_wr,
	output logic                   reg_we,
	output logic                   mem_reg,
	output logic [1:0]             mode_lsu
);

	logic is_ld;
	logic is_st;
	logic is_ar;

	////////////////////////////////////////
	// Opcode class
	////////////////////////////////////////
	always_comb begin
		is_ld = 1'b0;
		is_st = 1'b0;
		is_ar = 1'b0;
		case (instr[6:0])
			vec_issue_pkg::V_LOAD:  is_ld = 1'b1;
			vec_issue_pkg::V_STORE: is_st = 1'b1;
			vec_issue_pkg::V_ARITH: is_ar = 1'b1;
			default: ; // Scalar instruction
		endcase
	end

	assign is_vec = is_ld | is_st | is_ar;

	// Register fields, zero for scalar traffic
	assign vd      = is_vec ? instr[11:7] : '0;
	assign vs1     = is_vec ? instr[19:15] : '0;
	assign vs2     = is_vec ? instr[24:20] : '0;
	assign rs1_idx = is_vec ? instr[19:15] : '0; // Same bits feed the scalar read ports
	assign rs2_idx = is_vec ? instr[24:20] : '0;

	assign funct    = is_vec ? instr[31:26] : '0;
	assign mode_lsu = is_vec ? instr[27:26] : '0; // mop field of loads and stores
	assign mask_en  = is_vec & ~instr[25];         // vm=0 means masked

	// Memory and write-back controls
	assign mem_rd  = is_ld;
	assign mem_wr  = is_st;
	assign mem_reg = is_ld;          // Write-back data from memory
	assign reg_we  = is_ld | is_ar;

	// Operand source from funct3
	always_comb begin
		alu_src = vec_issue_pkg::SRC_VS;
		if (is_vec) begin
			case (instr[14:12])
				3'b100:  alu_src = vec_issue_pkg::SRC_RS;  // OPIVX
				3'b011:  alu_src = vec_issue_pkg::SRC_IMM; // OPIVI
				default: alu_src = vec_issue_pkg::SRC_VS;
			endcase
		end
	end

	always_comb begin
		a_mem_excl: assert (!(mem_rd && mem_wr))
			else $error("Decoder raised mem_rd and mem_wr for one instruction");
	end

endmodule

`default_nettype wire

/* vec_issue_pkg.sv */
`default_nettype none

package vec_issue_pkg;

	////////////////////////////////////////
	// Major opcodes of the vector extension
	////////////////////////////////////////
	typedef enum logic [6:0] {
		V_LOAD  = 7'b0000111, // Unit stride, strided or indexed load
		V_STORE = 7'b0100111, // Vector store
		V_ARITH = 7'b1010111  // OP-V arithmetic
	} vop_e;

	// Second operand source of the vector ALU, taken from funct3
	typedef enum logic [1:0] {
		SRC_VS  = 2'b00, // Vector register
		SRC_RS  = 2'b01, // Scalar register broadcast
		SRC_IMM = 2'b11  // 5 bit immediate
	} alu_src_e;

	////////////////////////////////////////
	// Convoy controller phases
	////////////////////////////////////////
	typedef enum logic [1:0] {
		CS_IDLE     = 2'b00, // Scalar pipeline owns the front end
		CS_COLLECT  = 2'b01, // Recording vector instructions
		CS_DISPATCH = 2'b10, // Issuing the recorded convoy
		CS_DRAIN    = 2'b11  // Waiting on completion and release count
	} conv_state_e;

endpackage

`default_nettype wire

/* vec_issue_params.svh */
`ifndef VEC_ISSUE_PARAMS_SVH
`define VEC_ISSUE_PARAMS_SVH

// Convoy size and collection window length
`define VI_NLANES 8

// Slot index into the instruction buffer
`define VI_SLOT_W 3

// Buffer occupancy, one bit wider than a slot
`define VI_CNT_W 4

// Scalar datapath
`define VI_XLEN 32

// Vector and scalar register index
`define VI_REG_W 5

// funct6 operation field
`define VI_FUNCT_W 6

// Unheld cycles after exe_done before control goes back to the scalar core
`define VI_RELEASE_THD 3

`endif
